// File: filelist.f
logic/fx3_bus_pkg.sv
logic/fx3_cmd_pkg.sv
logic/fx3_bus_controller.sv
logic/fx3_in_path.sv
logic/fx3_in_cmd_parser.sv
logic/fx3_out_path.sv
logic/fx3_bus_top.sv
verif/fx3_bus_tb.sv

// File: logic/fx3_bus_controller.sv
module fx3_bus_controller (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_master_rdy,
  input  logic                      i_in_path_busy,
  input  logic                      i_in_path_finished,
  input  logic                      i_out_path_ready,
  input  logic                      i_out_path_busy,
  input  logic                      i_out_path_finished,
  input  logic                      i_out_dma_buf_finished,
  input  fx3_bus_pkg::fx3_flags_t   i_flags,
  output logic                      o_in_path_enable,
  output logic                      o_in_path_cmd_enable,
  output logic                      o_out_path_enable,
  output logic                      o_out_dma_buf_ready,
  output fx3_bus_pkg::socket_addr_t o_socket_addr
);
  import fx3_bus_pkg::*;

  bus_dir_t r_state;
  logic     r_in_sel;
  logic     r_out_sel;
  logic     w_in_sel;
  logic     w_out_sel;
  logic     w_in_avail;
  logic     w_out_avail;
  logic     w_in_idle;
  logic     w_out_idle;

  assign w_in_avail  = i_flags.in_ch0_rdy | i_flags.in_ch1_rdy;
  assign w_out_avail = i_flags.out_ch0_rdy | i_flags.out_ch1_rdy;
  assign w_in_idle   = !o_in_path_enable && !i_in_path_busy;
  assign w_out_idle  = !o_out_path_enable && !i_out_path_busy;

  // ----------------------------------------
  // channel selection per direction
  // ----------------------------------------
  always_comb begin
    w_in_sel = r_in_sel;  // both or neither high keeps the last pick
    if (i_flags.in_ch0_rdy && !i_flags.in_ch1_rdy) begin
      w_in_sel = 1'b0;
    end else if (i_flags.in_ch1_rdy && !i_flags.in_ch0_rdy) begin
      w_in_sel = 1'b1;
    end
  end

  always_comb begin
    w_out_sel = r_out_sel;
    if (i_flags.out_ch0_rdy && !i_flags.out_ch1_rdy) begin
      w_out_sel = 1'b0;
    end else if (i_flags.out_ch1_rdy && !i_flags.out_ch0_rdy) begin
      w_out_sel = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_in_sel  <= 1'b0;
      r_out_sel <= 1'b0;
    end else begin
      r_in_sel  <= w_in_sel;
      r_out_sel <= w_out_sel;
    end
  end

  // ----------------------------------------
  // bus ownership
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      r_state              <= BUS_IDLE;
      o_in_path_enable     <= 1'b0;
      o_in_path_cmd_enable <= 1'b0;
      o_out_path_enable    <= 1'b0;
      o_out_dma_buf_ready  <= 1'b0;
      o_socket_addr        <= '0;
    end else begin
      if (i_master_rdy) begin
        o_in_path_cmd_enable <= 1'b1;
      end else if (w_in_idle && w_out_idle) begin
        o_in_path_cmd_enable <= 1'b0;  // only drop between packets
      end

      case (r_state)
        BUS_IDLE: begin
          if (w_in_avail && i_master_rdy && w_in_idle) begin
            o_socket_addr    <= {1'b0, w_in_sel};
            o_in_path_enable <= 1'b1;
            r_state          <= BUS_IN;
          end else if (i_out_path_ready && w_in_idle) begin
            o_out_path_enable <= 1'b1;
            r_state           <= BUS_OUT;
          end
        end
        BUS_IN: begin
          if (i_in_path_finished) begin
            o_in_path_enable <= 1'b0;
            r_state          <= BUS_IDLE;
          end
        end
        BUS_OUT: begin
          if (i_out_path_busy && w_out_avail && !o_out_dma_buf_ready) begin
            o_socket_addr       <= {1'b1, w_out_sel};
            o_out_dma_buf_ready <= 1'b1;
          end
          if (i_out_dma_buf_finished) begin
            o_out_dma_buf_ready <= 1'b0;
          end
          if (i_out_path_finished) begin
            o_out_dma_buf_ready <= 1'b0;
            o_out_path_enable   <= 1'b0;
            r_state             <= BUS_IDLE;
          end
        end
        default: begin
          r_state <= BUS_IDLE;
        end
      endcase
    end
  end

endmodule

// File: logic/fx3_bus_pkg.sv
package fx3_bus_pkg;

  typedef logic [31:0] fx3_word_t;

  // upper bit picks the direction (1 is outbound) and the lower bit the channel
  typedef logic [1:0] socket_addr_t;

  typedef struct packed {
    logic in_ch0_rdy;
    logic in_ch1_rdy;
    logic out_ch0_rdy;
    logic out_ch1_rdy;
  } fx3_flags_t;

  // ----------------------------------------
  // state encodings
  // ----------------------------------------
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_IN,
    BUS_OUT
  } bus_dir_t;

  typedef enum logic [1:0] {
    IN_IDLE,
    IN_READ,
    IN_DRAIN,
    IN_DONE
  } in_state_t;

  typedef enum logic [1:0] {
    OUT_IDLE,
    OUT_WAIT_BUF,
    OUT_WRITE,
    OUT_DONE
  } out_state_t;

endpackage

// File: logic/fx3_bus_top.sv
module fx3_bus_top #(
  parameter int READ_LATENCY = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_master_rdy,
  input  fx3_bus_pkg::fx3_flags_t   i_fx3_flags,
  input  fx3_bus_pkg::fx3_word_t    i_fx3_data,
  input  fx3_cmd_pkg::resp_t        i_resp,
  input  logic                      i_resp_stb,
  output fx3_bus_pkg::socket_addr_t o_socket_addr,
  output logic                      o_fx3_rd,
  output logic                      o_fx3_wr,
  output fx3_bus_pkg::fx3_word_t    o_fx3_data,
  output fx3_cmd_pkg::cmd_t         o_cmd,
  output logic                      o_cmd_stb,
  output logic                      o_cmd_err
);
  import fx3_bus_pkg::*;

  logic      w_in_path_enable;
  logic      w_in_path_busy;
  logic      w_in_path_finished;
  logic      w_in_path_cmd_enable;
  logic      w_out_path_ready;
  logic      w_out_path_busy;
  logic      w_out_path_finished;
  logic      w_out_path_enable;
  logic      w_out_dma_buf_ready;
  logic      w_out_dma_buf_finished;
  logic      w_word_stb;
  logic      w_pkt_start;
  fx3_word_t w_word;

  // ----------------------------------------
  // arbiter
  // ----------------------------------------
  fx3_bus_controller u_controller (
    .clk                    (clk),
    .rst                    (rst),
    .i_master_rdy           (i_master_rdy),
    .i_in_path_busy         (w_in_path_busy),
    .i_in_path_finished     (w_in_path_finished),
    .i_out_path_ready       (w_out_path_ready),
    .i_out_path_busy        (w_out_path_busy),
    .i_out_path_finished    (w_out_path_finished),
    .i_out_dma_buf_finished (w_out_dma_buf_finished),
    .i_flags                (i_fx3_flags),
    .o_in_path_enable       (w_in_path_enable),
    .o_in_path_cmd_enable   (w_in_path_cmd_enable),
    .o_out_path_enable      (w_out_path_enable),
    .o_out_dma_buf_ready    (w_out_dma_buf_ready),
    .o_socket_addr          (o_socket_addr)
  );

  // ----------------------------------------
  // inbound command side
  // ----------------------------------------
  fx3_in_path #(
    .READ_LATENCY (READ_LATENCY)
  ) u_in_path (
    .clk         (clk),
    .rst         (rst),
    .i_enable    (w_in_path_enable),
    .i_fx3_data  (i_fx3_data),
    .o_busy      (w_in_path_busy),
    .o_finished  (w_in_path_finished),
    .o_fx3_rd    (o_fx3_rd),
    .o_word_stb  (w_word_stb),
    .o_word      (w_word),
    .o_pkt_start (w_pkt_start)
  );

  fx3_in_cmd_parser u_cmd_parser (
    .clk         (clk),
    .rst         (rst),
    .i_enable    (w_in_path_cmd_enable),
    .i_pkt_start (w_pkt_start),
    .i_word_stb  (w_word_stb),
    .i_word      (w_word),
    .o_cmd       (o_cmd),
    .o_cmd_stb   (o_cmd_stb),
    .o_cmd_err   (o_cmd_err)
  );

  // outbound response side
  fx3_out_path u_out_path (
    .clk                (clk),
    .rst                (rst),
    .i_resp             (i_resp),
    .i_resp_stb         (i_resp_stb),
    .i_enable           (w_out_path_enable),
    .i_dma_buf_ready    (w_out_dma_buf_ready),
    .o_ready            (w_out_path_ready),
    .o_busy             (w_out_path_busy),
    .o_finished         (w_out_path_finished),
    .o_dma_buf_finished (w_out_dma_buf_finished),
    .o_fx3_wr           (o_fx3_wr),
    .o_fx3_data         (o_fx3_data)
  );

endmodule

// File: logic/fx3_cmd_pkg.sv
package fx3_cmd_pkg;

  typedef enum logic [3:0] {
    OP_PING  = 4'h0,
    OP_WRITE = 4'h1,
    OP_READ  = 4'h2,
    OP_RESET = 4'h3
  } cmd_op_t;

  localparam logic [7:0] CMD_MAGIC  = 8'hCD;
  localparam logic [7:0] RESP_MAGIC = 8'hDC;

  // packet sizes in 32 bit words
  localparam int CMD_WORDS  = 3;
  localparam int RESP_WORDS = 2;

  // ----------------------------------------
  // decoded command and response payloads
  // ----------------------------------------
  typedef struct packed {
    cmd_op_t     opcode;
    logic [15:0] id;
    logic [31:0] addr;
    logic [31:0] data;
  } cmd_t;

  typedef struct packed {
    logic [15:0] status;
    logic [31:0] data;
  } resp_t;

endpackage

// File: logic/fx3_in_cmd_parser.sv
module fx3_in_cmd_parser (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_enable,
  input  logic                   i_pkt_start,
  input  logic                   i_word_stb,
  input  fx3_bus_pkg::fx3_word_t i_word,
  output fx3_cmd_pkg::cmd_t      o_cmd,
  output logic                   o_cmd_stb,
  output logic                   o_cmd_err
);
  import fx3_cmd_pkg::*;

  localparam int CNT_W = $clog2(CMD_WORDS + 1);

  logic [CNT_W-1:0] r_word_cnt;
  logic             r_magic_ok;
  logic             w_take;

  // words past the end of a packet are dropped
  assign w_take = i_word_stb && i_enable && (r_word_cnt < CNT_W'(CMD_WORDS));

  always_ff @(posedge clk) begin
    if (rst) begin
      r_word_cnt <= '0;
      r_magic_ok <= 1'b0;
      o_cmd_stb  <= 1'b0;
      o_cmd_err  <= 1'b0;
    end else begin
      o_cmd_stb <= 1'b0;
      o_cmd_err <= 1'b0;
      if (i_pkt_start) begin
        r_word_cnt <= '0;
      end else if (w_take) begin
        r_word_cnt <= r_word_cnt + 1'b1;
        if (r_word_cnt == '0) begin
          r_magic_ok <= (i_word[31:24] == CMD_MAGIC);
        end
        if (r_word_cnt == CNT_W'(CMD_WORDS - 1)) begin
          o_cmd_stb <= r_magic_ok;
          o_cmd_err <= !r_magic_ok;  // whole packet still consumed
        end
      end
    end
  end

  // ----------------------------------------
  // field placement
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (w_take && !i_pkt_start) begin
      case (r_word_cnt)
        CNT_W'(0): begin
          o_cmd.opcode <= cmd_op_t'(i_word[19:16]);
          o_cmd.id     <= i_word[15:0];
        end
        CNT_W'(1): begin
          o_cmd.addr <= i_word;
        end
        default: begin
          o_cmd.data <= i_word;
        end
      endcase
    end
  end

endmodule

// File: logic/fx3_in_path.sv
module fx3_in_path #(
  parameter int READ_LATENCY = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_enable,
  input  fx3_bus_pkg::fx3_word_t i_fx3_data,
  output logic                   o_busy,
  output logic                   o_finished,
  output logic                   o_fx3_rd,
  output logic                   o_word_stb,
  output fx3_bus_pkg::fx3_word_t o_word,
  output logic                   o_pkt_start
);
  import fx3_bus_pkg::*;
  import fx3_cmd_pkg::*;

  localparam int CNT_W = $clog2(CMD_WORDS + 1);

  in_state_t               r_state;
  logic [CNT_W-1:0]        r_rd_cnt;
  logic [CNT_W-1:0]        r_ret_cnt;
  logic [READ_LATENCY-1:0] r_rd_pipe;
  logic                    w_data_valid;

  // a read strobe comes back as valid data READ_LATENCY cycles later
  assign w_data_valid = r_rd_pipe[READ_LATENCY-1];
  assign o_busy       = (r_state != IN_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      r_state     <= IN_IDLE;
      r_rd_cnt    <= '0;
      r_ret_cnt   <= '0;
      r_rd_pipe   <= '0;
      o_fx3_rd    <= 1'b0;
      o_finished  <= 1'b0;
      o_word_stb  <= 1'b0;
      o_pkt_start <= 1'b0;
    end else begin
      o_finished  <= 1'b0;
      o_word_stb  <= 1'b0;
      o_pkt_start <= 1'b0;
      r_rd_pipe   <= (r_rd_pipe << 1) | READ_LATENCY'(o_fx3_rd);

      case (r_state)
        IN_IDLE: begin
          if (i_enable) begin
            o_fx3_rd    <= 1'b1;
            o_pkt_start <= 1'b1;
            r_rd_cnt    <= CNT_W'(1);
            r_ret_cnt   <= '0;
            r_state     <= IN_READ;
          end
        end
        IN_READ: begin
          if (r_rd_cnt < CNT_W'(CMD_WORDS)) begin
            o_fx3_rd <= 1'b1;
            r_rd_cnt <= r_rd_cnt + 1'b1;
          end else begin
            o_fx3_rd <= 1'b0;
            r_state  <= IN_DRAIN;
          end
        end
        IN_DRAIN: begin
          o_fx3_rd <= 1'b0;  // waiting on the read pipeline
        end
        IN_DONE: begin
          r_state <= IN_IDLE;
        end
        default: begin
          r_state <= IN_IDLE;
        end
      endcase

      if (w_data_valid) begin
        o_word_stb <= 1'b1;
        r_ret_cnt  <= r_ret_cnt + 1'b1;
        if (r_ret_cnt == CNT_W'(CMD_WORDS - 1)) begin
          o_finished <= 1'b1;
          r_state    <= IN_DONE;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (w_data_valid) begin
      o_word <= i_fx3_data;
    end
  end

endmodule

// File: logic/fx3_out_path.sv
module fx3_out_path (
  input  logic                   clk,
  input  logic                   rst,
  input  fx3_cmd_pkg::resp_t     i_resp,
  input  logic                   i_resp_stb,
  input  logic                   i_enable,
  input  logic                   i_dma_buf_ready,
  output logic                   o_ready,
  output logic                   o_busy,
  output logic                   o_finished,
  output logic                   o_dma_buf_finished,
  output logic                   o_fx3_wr,
  output fx3_bus_pkg::fx3_word_t o_fx3_data
);
  import fx3_bus_pkg::*;
  import fx3_cmd_pkg::*;

  localparam int CNT_W = $clog2(RESP_WORDS + 1);

  out_state_t       r_state;
  resp_t            r_resp;
  logic             r_pending;
  logic [CNT_W-1:0] r_word_cnt;
  logic             w_capture;
  logic             w_wr_next;
  fx3_word_t        w_next_word;

  assign w_capture = i_resp_stb && !r_pending;  // a second response waits its turn upstream
  assign o_ready   = r_pending && (r_state == OUT_IDLE);
  assign o_busy    = (r_state == OUT_WAIT_BUF) || (r_state == OUT_WRITE);

  assign w_wr_next = ((r_state == OUT_WAIT_BUF) && i_dma_buf_ready) ||
                     ((r_state == OUT_WRITE) && (r_word_cnt < CNT_W'(RESP_WORDS)));

  // header first, then the data word
  assign w_next_word = (r_word_cnt == '0) ? {RESP_MAGIC, 8'h00, r_resp.status}
                                          : r_resp.data;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_state            <= OUT_IDLE;
      r_pending          <= 1'b0;
      r_word_cnt         <= '0;
      o_fx3_wr           <= 1'b0;
      o_dma_buf_finished <= 1'b0;
      o_finished         <= 1'b0;
    end else begin
      o_fx3_wr           <= w_wr_next;
      o_dma_buf_finished <= 1'b0;
      o_finished         <= 1'b0;
      if (w_capture) begin
        r_pending <= 1'b1;
      end

      case (r_state)
        OUT_IDLE: begin
          r_word_cnt <= '0;
          if (i_enable && r_pending) begin
            r_state <= OUT_WAIT_BUF;
          end
        end
        OUT_WAIT_BUF: begin
          if (i_dma_buf_ready) begin
            r_word_cnt <= r_word_cnt + 1'b1;
            r_state    <= OUT_WRITE;
          end
        end
        OUT_WRITE: begin
          if (r_word_cnt < CNT_W'(RESP_WORDS)) begin
            r_word_cnt <= r_word_cnt + 1'b1;
          end else begin
            o_dma_buf_finished <= 1'b1;
            r_state            <= OUT_DONE;
          end
        end
        OUT_DONE: begin
          o_finished <= 1'b1;
          r_pending  <= 1'b0;
          r_state    <= OUT_IDLE;
        end
        default: begin
          r_state <= OUT_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (w_capture) begin
      r_resp <= i_resp;
    end
    if (w_wr_next) begin
      o_fx3_data <= w_next_word;
    end
  end

endmodule

// File: verif/fx3_bus_cases.txt
# C ch op id addr data magic_ok | R ch status data | H master hold check
# fields are hex, one case per line
C 0 0 0001 00000000 00000000 1
C 1 1 0002 00001000 deadbeef 1
R 0 0000 cafef00d
R 1 0001 0badc0de
C 0 2 00a5 00001004 00000000 1
C 1 3 ffff ffffffff 12345678 1
H
C 0 1 0042 80000000 a5a5a5a5 0
R 1 8001 ffffffff
C 1 1 1234 0000fffc 5a5a5a5a 1
C 1 2 7e7e 00010000 00000001 0
R 0 00ff 00000000
H
C 0 3 beef 0badf00d 76543210 1
R 1 1234 89abcdef
C 1 0 0100 00000010 00000020 1
R 0 ffff 13579bdf

// File: verif/fx3_bus_tb.sv
module fx3_bus_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import fx3_bus_pkg::*;
  import fx3_cmd_pkg::*;

  localparam int READ_LATENCY = 2;
  localparam int RESET_CYCLES = 16;
  localparam int CASE_CYCLES  = 200;
  localparam int HOLD_CYCLES  = 50;
  localparam int BP_CYCLES    = 20;  // cycles a response waits with the outbound flag low

  typedef struct packed {
    logic [7:0] kind;
    logic       ch;
    logic       magic_ok;
    cmd_t       cmd;
    resp_t      resp;
  } case_t;

  logic         clk = 1'b0;
  logic         rst;
  logic         i_master_rdy;
  fx3_flags_t   i_fx3_flags;
  fx3_word_t    i_fx3_data;
  resp_t        i_resp;
  logic         i_resp_stb;
  socket_addr_t o_socket_addr;
  logic         o_fx3_rd;
  logic         o_fx3_wr;
  fx3_word_t    o_fx3_data;
  cmd_t         o_cmd;
  logic         o_cmd_stb;
  logic         o_cmd_err;

  case_t     cases[$];
  fx3_word_t rd_q[$];  // words the socket model hands out on reads
  fx3_word_t wr_q[$];  // words seen on writes
  bit        cases_loaded = 1'b0;
  logic      exp_ch = 1'b0;
  logic      rd_sampled = 1'b0;
  logic      rd_seen = 1'b0;
  int        rd_cnt = 0;
  int        stb_cnt = 0;
  int        err_cnt = 0;
  cmd_t      got_cmd;
  integer    seed = 32'hcc5f;

  fx3_bus_top #(
    .READ_LATENCY (READ_LATENCY)
  ) UUT (
    .clk           (clk),
    .rst           (rst),
    .i_master_rdy  (i_master_rdy),
    .i_fx3_flags   (i_fx3_flags),
    .i_fx3_data    (i_fx3_data),
    .i_resp        (i_resp),
    .i_resp_stb    (i_resp_stb),
    .o_socket_addr (o_socket_addr),
    .o_fx3_rd      (o_fx3_rd),
    .o_fx3_wr      (o_fx3_wr),
    .o_fx3_data    (o_fx3_data),
    .o_cmd         (o_cmd),
    .o_cmd_stb     (o_cmd_stb),
    .o_cmd_err     (o_cmd_err)
  );

  always #10 clk = ~clk;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time %0d ns signal %s got %h expected %h",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input fx3_word_t got, input fx3_word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time %0d ns signal %s got %h expected %h",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_socket(input string name, input socket_addr_t got,
                              input socket_addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time %0d ns signal %s got %b expected %b",
                         $time, name, got, exp));
    end
  endtask

  // ----------------------------------------
  // GPIF socket model and output monitor
  // ----------------------------------------
  always @(negedge clk) begin
    rd_sampled = !rst && o_fx3_rd;
    if (!rst) begin
      if (o_fx3_rd) begin
        check_socket("o_socket_addr", o_socket_addr, {1'b0, exp_ch});
        rd_cnt = rd_cnt + 1;
      end
      if (o_fx3_wr) begin
        check_socket("o_socket_addr", o_socket_addr, {1'b1, exp_ch});
        wr_q.push_back(o_fx3_data);
      end
      if (o_cmd_stb) begin
        stb_cnt = stb_cnt + 1;
        got_cmd = o_cmd;
      end
      if (o_cmd_err) begin
        err_cnt = err_cnt + 1;
      end
    end
  end

  always @(posedge clk) begin
    rd_seen <= rd_sampled;  // the extra stage makes the data land two cycles after the strobe
    if (rd_seen) begin
      if (rd_q.size() == 0) begin
        fail_run("read strobe arrived with no word queued in the socket model");
      end else begin
        i_fx3_data <= rd_q.pop_front();
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic idle_gap();
    int gap;
    gap = 4 + ($unsigned($random(seed)) % 12);
    repeat (gap) @(posedge clk);
  endtask

  task automatic queue_cmd_words(input cmd_t cmd, input logic magic_ok);
    logic [7:0] magic;
    magic = magic_ok ? CMD_MAGIC : ~CMD_MAGIC;
    rd_q.push_back({magic, 4'h0, cmd.opcode, cmd.id});
    rd_q.push_back(cmd.addr);
    rd_q.push_back(cmd.data);
  endtask

  // the inbound flag is already up when this starts
  task automatic finish_cmd(input cmd_t exp, input logic magic_ok);
    while (rd_cnt < CMD_WORDS) @(posedge clk);
    i_fx3_flags <= '0;
    while (stb_cnt + err_cnt == 0) @(posedge clk);
    idle_gap();
    if (rd_cnt != CMD_WORDS) begin
      fail_run($sformatf("command packet took %0d reads instead of %0d", rd_cnt, CMD_WORDS));
    end
    if (magic_ok) begin
      if (stb_cnt != 1 || err_cnt != 0) begin
        fail_run($sformatf("valid command gave %0d strobes and %0d errors", stb_cnt, err_cnt));
      end
      check_cmd("o_cmd", got_cmd, exp);
    end else if (err_cnt != 1 || stb_cnt != 0) begin
      fail_run($sformatf("bad magic gave %0d strobes and %0d errors", stb_cnt, err_cnt));
    end
  endtask

  task automatic run_cmd(input case_t c);
    fx3_flags_t flags;
    exp_ch  = c.ch;
    rd_cnt  = 0;
    stb_cnt = 0;
    err_cnt = 0;
    queue_cmd_words(c.cmd, c.magic_ok);
    flags            = '0;
    flags.in_ch0_rdy = !c.ch;
    flags.in_ch1_rdy = c.ch;
    i_fx3_flags <= flags;
    finish_cmd(c.cmd, c.magic_ok);
  endtask

  task automatic run_hold();
    cmd_t       cmd;
    fx3_flags_t flags;
    cmd.opcode = OP_WRITE;
    cmd.id     = 16'($random(seed));
    cmd.addr   = $random(seed);
    cmd.data   = $random(seed);
    exp_ch  = 1'b0;
    rd_cnt  = 0;
    stb_cnt = 0;
    err_cnt = 0;
    queue_cmd_words(cmd, 1'b1);
    flags            = '0;
    flags.in_ch0_rdy = 1'b1;
    i_master_rdy <= 1'b0;
    i_fx3_flags  <= flags;
    repeat (HOLD_CYCLES) @(posedge clk);
    if (rd_cnt != 0) begin
      fail_run("inbound read started while the master was not ready");
    end
    i_master_rdy <= 1'b1;
    finish_cmd(cmd, 1'b1);
  endtask

  task automatic run_resp(input case_t c);
    fx3_flags_t flags;
    exp_ch = c.ch;
    wr_q.delete();
    i_resp     <= c.resp;
    i_resp_stb <= 1'b1;
    @(posedge clk);
    i_resp_stb <= 1'b0;
    repeat (BP_CYCLES) @(posedge clk);
    if (wr_q.size() != 0) begin
      fail_run("response was written while the outbound flag was low");
    end
    flags             = '0;
    flags.out_ch0_rdy = !c.ch;
    flags.out_ch1_rdy = c.ch;
    i_fx3_flags <= flags;
    while (wr_q.size() < RESP_WORDS) @(posedge clk);
    i_fx3_flags <= '0;
    idle_gap();
    if (wr_q.size() != RESP_WORDS) begin
      fail_run($sformatf("response took %0d writes instead of %0d", wr_q.size(), RESP_WORDS));
    end
    check_word("o_fx3_data header", wr_q[0], {RESP_MAGIC, 8'h00, c.resp.status});
    check_word("o_fx3_data data", wr_q[1], c.resp.data);
  endtask

  initial begin
    int          fd;
    int          n;
    int          ch_i;
    logic [7:0]  kind;
    logic [31:0] f_ch;
    logic [31:0] f_op;
    logic [31:0] f_id;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_ok;
    case_t       c;
    rst          <= 1'b1;
    i_master_rdy <= 1'b1;
    i_fx3_flags  <= '0;
    i_fx3_data   <= '0;
    i_resp       <= '0;
    i_resp_stb   <= 1'b0;

    fd = $fopen("verif/fx3_bus_cases.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open verif/fx3_bus_cases.txt");
    end
    while ($fscanf(fd, " %c", kind) == 1) begin
      c      = '0;
      c.kind = kind;
      if (kind == "#") begin
        ch_i = $fgetc(fd);
        while (ch_i != 10 && ch_i != -1) ch_i = $fgetc(fd);
      end else if (kind == "C") begin
        n = $fscanf(fd, "%h %h %h %h %h %h", f_ch, f_op, f_id, f_addr, f_data, f_ok);
        if (n != 6) begin
          fail_run("malformed command line in the case file");
        end
        c.ch         = f_ch[0];
        c.magic_ok   = f_ok[0];
        c.cmd.opcode = cmd_op_t'(f_op[3:0]);
        c.cmd.id     = f_id[15:0];
        c.cmd.addr   = f_addr;
        c.cmd.data   = f_data;
        cases.push_back(c);
      end else if (kind == "R") begin
        n = $fscanf(fd, "%h %h %h", f_ch, f_id, f_data);
        if (n != 3) begin
          fail_run("malformed response line in the case file");
        end
        c.ch          = f_ch[0];
        c.resp.status = f_id[15:0];
        c.resp.data   = f_data;
        cases.push_back(c);
      end else if (kind == "H") begin
        cases.push_back(c);
      end else begin
        fail_run("unknown case kind in the case file");
      end
    end
    $fclose(fd);
    if (cases.size() == 0) begin
      fail_run("case file holds no cases");
    end
    cases_loaded = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    idle_gap();
    foreach (cases[i]) begin
      case (cases[i].kind)
        "C":     run_cmd(cases[i]);
        "R":     run_resp(cases[i]);
        default: run_hold();
      endcase
    end
    $display("Finished with no errors");
    $finish;
  end

  // watchdog
  initial begin
    wait (cases_loaded);
    repeat (RESET_CYCLES + CASE_CYCLES * cases.size()) @(posedge clk);
    fail_run("watchdog expired before all cases completed");
  end

endmodule
